//--- source/bpred_macros.svh
`ifndef BPRED_MACROS_SVH
`define BPRED_MACROS_SVH

// instruction and address width
`define WORD_SIZE 16

// low pc bits index the btb and bht, the rest is the tag
`define BTB_INDEX_BITS 4
`define BTB_TAG_BITS 12

// immediate fields
`define BRANCH_IMM_BITS 8
`define JUMP_IMM_BITS 12

`define BHT_INIT 2'd1 // weakly not taken

`endif

//--- source/bpred_pkg.sv
`include "bpred_macros.svh"

package bpred_pkg;

        typedef logic [`WORD_SIZE-1:0] word_t;

        // opcode field, instr[15:12]
        typedef enum logic [3:0] {
                BNE   = 4'd0,
                BEQ   = 4'd1,
                BGZ   = 4'd2,
                BLZ   = 4'd3,
                JMP   = 4'd9,
                JAL   = 4'd10,
                RTYPE = 4'd15
        } opcode_e;

        // function field of r-type, instr[5:0]
        typedef enum logic [5:0] {
                JPR = 6'd25, // jump to rs
                JRL = 6'd26  // jump to rs and link
        } func_e;

        // 2-bit saturating counter
        //   0,1 not taken / 2,3 taken
        typedef logic [1:0] bht_ctr_t;

        // one btb line, 30 bits
        typedef struct packed {
                logic                     valid;
                logic [`BTB_TAG_BITS-1:0] tag;
                word_t                    target;
                logic                     is_jump; // predict taken regardless of bht
        } btb_entry_t;

endpackage

//--- source/bpred_ifc.sv
`timescale 1ns/1ps

// training writes from the resolver into btb and bht
interface predictor_update_if;
        import bpred_pkg::*;

        logic  btb_write;  // tag miss on a branch or jump in id
        word_t btb_pc;
        word_t btb_target;
        logic  btb_jump;

        logic  bht_write;  // conditional branch resolved in ex
        word_t bht_pc;
        logic  bht_taken;

        modport resolver (
                output btb_write, btb_pc, btb_target, btb_jump,
                output bht_write, bht_pc, bht_taken
        );

        modport predictor (
                input btb_write, btb_pc, btb_target, btb_jump,
                input bht_write, bht_pc, bht_taken
        );
endinterface

// pc redirects from the resolver into the pc register
interface redirect_if;
        import bpred_pkg::*;

        logic  jump_resolved;
        logic  jump_miss;
        word_t jump_target;
        logic  branch_resolved;
        logic  branch_miss;
        word_t branch_target; // actual address, taken or fall-through

        modport resolver (
                output jump_resolved, jump_miss, jump_target,
                output branch_resolved, branch_miss, branch_target
        );

        modport selector (
                input jump_resolved, jump_miss, jump_target,
                input branch_resolved, branch_miss, branch_target
        );
endinterface

//--- source/branch_predictor.sv
`timescale 1ns/1ps
`include "bpred_macros.svh"

module branch_predictor (
        input  logic                  clk,
        input  logic                  reset_n,
        input  bpred_pkg::word_t      i_fetch_pc,
        predictor_update_if.predictor upd,
        output bpred_pkg::word_t      o_predicted_pc,
        output logic                  o_tag_match
);
        import bpred_pkg::*;

        localparam int BTB_DEPTH = 1 << `BTB_INDEX_BITS;

        btb_entry_t btb_mem [BTB_DEPTH];
        bht_ctr_t   bht_mem [BTB_DEPTH];

        logic [`BTB_INDEX_BITS-1:0] fetch_idx;
        logic [`BTB_TAG_BITS-1:0]   fetch_tag;
        btb_entry_t                 fetch_entry;
        bht_ctr_t                   fetch_ctr;

        logic [`BTB_INDEX_BITS-1:0] btb_idx;
        logic [`BTB_INDEX_BITS-1:0] bht_idx;
        bht_ctr_t                   bht_cur;
        bht_ctr_t                   bht_nxt;

        // ------------------------------------------------------------
        // fetch-time lookup
        // ------------------------------------------------------------
        assign fetch_idx   = i_fetch_pc[`BTB_INDEX_BITS-1:0];
        assign fetch_tag   = i_fetch_pc[`WORD_SIZE-1:`BTB_INDEX_BITS];
        assign fetch_entry = btb_mem[fetch_idx];
        assign fetch_ctr   = bht_mem[fetch_idx];

        assign o_tag_match = fetch_entry.valid && (fetch_entry.tag == fetch_tag);

        always_comb begin
                if (o_tag_match && (fetch_entry.is_jump || fetch_ctr >= 2'd2)) begin
                        o_predicted_pc = fetch_entry.target;
                end else begin
                        o_predicted_pc = i_fetch_pc + word_t'(1); // fall through
                end
        end

        // ------------------------------------------------------------
        // training
        // ------------------------------------------------------------
        assign btb_idx = upd.btb_pc[`BTB_INDEX_BITS-1:0];
        assign bht_idx = upd.bht_pc[`BTB_INDEX_BITS-1:0];
        assign bht_cur = bht_mem[bht_idx];

        // saturating step of the resolved counter
        always_comb begin
                if (upd.bht_taken) begin
                        bht_nxt = (bht_cur == 2'd3) ? bht_cur : bht_ctr_t'(bht_cur + 2'd1);
                end else begin
                        bht_nxt = (bht_cur == 2'd0) ? bht_cur : bht_ctr_t'(bht_cur - 2'd1);
                end
        end

        always_ff @(posedge clk) begin
                if (reset_n) begin
                        for (int i = 0; i < BTB_DEPTH; i++) begin
                                btb_mem[i] <= '0;
                                bht_mem[i] <= `BHT_INIT;
                        end
                end else begin
                        if (upd.btb_write) begin
                                btb_mem[btb_idx].valid   <= 1'b1;
                                btb_mem[btb_idx].tag     <= upd.btb_pc[`WORD_SIZE-1:`BTB_INDEX_BITS];
                                btb_mem[btb_idx].target  <= upd.btb_target;
                                btb_mem[btb_idx].is_jump <= upd.btb_jump;
                                bht_mem[btb_idx]         <= `BHT_INIT; // fresh tag
                        end
                        // placed last so a same-index update wins over the reset
                        if (upd.bht_write) begin
                                bht_mem[bht_idx] <= bht_nxt;
                        end
                end
        end

endmodule

//--- source/branch_resolver.sv
`timescale 1ns/1ps
`include "bpred_macros.svh"

module branch_resolver (
        input  logic                 clk,
        input  logic                 reset_n,
        input  logic                 i_id_valid,
        input  bpred_pkg::word_t     i_id_instr,
        input  bpred_pkg::word_t     i_id_pc,
        input  bpred_pkg::word_t     i_id_predicted_pc,
        input  logic                 i_id_tag_match,
        input  bpred_pkg::word_t     i_id_rs_data,
        input  bpred_pkg::word_t     i_ex_rs_data,
        input  bpred_pkg::word_t     i_ex_rt_data,
        predictor_update_if.resolver upd,
        redirect_if.resolver         rdr,
        output logic                 o_flush_id,
        output logic                 o_flush_ex
);
        import bpred_pkg::*;

        opcode_e id_op;
        func_e   id_func;
        logic    id_is_reg_jump;
        logic    id_is_jump;
        logic    id_is_branch;
        word_t   jump_target;
        word_t   branch_offset;
        word_t   branch_target;

        // branch slot, id -> ex
        logic    slot_valid;
        opcode_e slot_op;
        word_t   slot_pc;
        word_t   slot_pred_pc;
        word_t   slot_target;

        logic    ex_taken;
        word_t   ex_actual_pc;

        // ------------------------------------------------------------
        // id stage
        // ------------------------------------------------------------
        assign id_op   = opcode_e'(i_id_instr[15:12]);
        assign id_func = func_e'(i_id_instr[5:0]);

        assign id_is_reg_jump = (id_op == RTYPE) && (id_func == JPR || id_func == JRL);

        // a branch miss in ex cancels whatever sits in id
        assign id_is_jump   = i_id_valid && !rdr.branch_miss &&
                              (id_op == JMP || id_op == JAL || id_is_reg_jump);
        assign id_is_branch = i_id_valid && !rdr.branch_miss &&
                              (id_op inside {BNE, BEQ, BGZ, BLZ});

        assign jump_target = id_is_reg_jump ? i_id_rs_data :
                {i_id_pc[`WORD_SIZE-1:`JUMP_IMM_BITS], i_id_instr[`JUMP_IMM_BITS-1:0]};

        assign branch_offset = {{(`WORD_SIZE-`BRANCH_IMM_BITS){i_id_instr[`BRANCH_IMM_BITS-1]}},
                                i_id_instr[`BRANCH_IMM_BITS-1:0]};
        assign branch_target = i_id_pc + word_t'(1) + branch_offset;

        assign rdr.jump_resolved = id_is_jump;
        assign rdr.jump_miss     = id_is_jump && (jump_target != i_id_predicted_pc);
        assign rdr.jump_target   = jump_target;

        // allocate the btb line on a tag miss
        assign upd.btb_write  = (id_is_jump || id_is_branch) && !i_id_tag_match;
        assign upd.btb_pc     = i_id_pc;
        assign upd.btb_target = id_is_jump ? jump_target : branch_target;
        assign upd.btb_jump   = id_is_jump;

        always_ff @(posedge clk) begin
                if (reset_n) begin
                        slot_valid <= 1'b0;
                end else begin
                        slot_valid <= id_is_branch; // loaded invalid on a branch miss
                end
        end

        always_ff @(posedge clk) begin
                slot_op      <= id_op;
                slot_pc      <= i_id_pc;
                slot_pred_pc <= i_id_predicted_pc;
                slot_target  <= branch_target;
        end

        // ------------------------------------------------------------
        // ex stage
        // ------------------------------------------------------------
        always_comb begin
                case (slot_op)
                        BEQ:     ex_taken = (i_ex_rs_data == i_ex_rt_data);
                        BNE:     ex_taken = (i_ex_rs_data != i_ex_rt_data);
                        BGZ:     ex_taken = ($signed(i_ex_rs_data) > 0);
                        BLZ:     ex_taken = ($signed(i_ex_rs_data) < 0);
                        default: ex_taken = 1'b0;
                endcase
        end

        assign ex_actual_pc = ex_taken ? slot_target : slot_pc + word_t'(1);

        assign rdr.branch_resolved = slot_valid;
        assign rdr.branch_miss     = slot_valid && (ex_actual_pc != slot_pred_pc);
        assign rdr.branch_target   = ex_actual_pc;

        assign upd.bht_write = slot_valid;
        assign upd.bht_pc    = slot_pc;
        assign upd.bht_taken = ex_taken;

        assign o_flush_id = rdr.jump_miss || rdr.branch_miss;
        assign o_flush_ex = rdr.branch_miss;

endmodule

//--- source/pc_select.sv
`timescale 1ns/1ps

module pc_select (
        input  logic             clk,
        input  logic             reset_n,
        input  bpred_pkg::word_t i_predicted_pc,
        redirect_if.selector     rdr,
        output bpred_pkg::word_t o_pc,
        output bpred_pkg::word_t o_num_branch,
        output bpred_pkg::word_t o_num_branch_miss
);
        import bpred_pkg::*;

        word_t next_pc;
        word_t branch_inc;
        logic  any_miss;

        // ex redirect is older than id, so it comes first
        always_comb begin
                if (rdr.branch_miss) begin
                        next_pc = rdr.branch_target;
                end else if (rdr.jump_miss) begin
                        next_pc = rdr.jump_target;
                end else begin
                        next_pc = i_predicted_pc;
                end
        end

        // up to two resolutions per cycle, one per stage
        assign branch_inc = word_t'(rdr.jump_resolved) + word_t'(rdr.branch_resolved);
        assign any_miss   = rdr.jump_miss || rdr.branch_miss;

        always_ff @(posedge clk) begin
                if (reset_n) begin
                        o_pc              <= '0;
                        o_num_branch      <= '0;
                        o_num_branch_miss <= '0;
                end else begin
                        o_pc         <= next_pc;
                        o_num_branch <= o_num_branch + branch_inc;
                        if (any_miss) begin
                                o_num_branch_miss <= o_num_branch_miss + word_t'(1);
                        end
                end
        end

endmodule

//--- source/next_pc_unit.sv
`timescale 1ns/1ps

module next_pc_unit (
        input  logic             clk,
        input  logic             reset_n,

        // if/id register contents, held by the environment
        input  logic             i_id_valid,
        input  bpred_pkg::word_t i_id_instr,
        input  bpred_pkg::word_t i_id_pc,
        input  bpred_pkg::word_t i_id_predicted_pc,
        input  logic             i_id_tag_match,
        input  bpred_pkg::word_t i_id_rs_data,

        // register values of the branch in ex
        input  bpred_pkg::word_t i_ex_rs_data,
        input  bpred_pkg::word_t i_ex_rt_data,

        output bpred_pkg::word_t o_pc,
        output bpred_pkg::word_t o_predicted_pc,
        output logic             o_tag_match,
        output logic             o_flush_id,
        output logic             o_flush_ex,
        output bpred_pkg::word_t o_num_branch,
        output bpred_pkg::word_t o_num_branch_miss
);

        predictor_update_if upd_if ();
        redirect_if         rdr_if ();

        branch_predictor branch_predictor_inst (
                .clk            (clk),
                .reset_n        (reset_n),
                .i_fetch_pc     (o_pc),
                .upd            (upd_if.predictor),
                .o_predicted_pc (o_predicted_pc),
                .o_tag_match    (o_tag_match)
        );

        branch_resolver branch_resolver_inst (
                .clk               (clk),
                .reset_n           (reset_n),
                .i_id_valid        (i_id_valid),
                .i_id_instr        (i_id_instr),
                .i_id_pc           (i_id_pc),
                .i_id_predicted_pc (i_id_predicted_pc),
                .i_id_tag_match    (i_id_tag_match),
                .i_id_rs_data      (i_id_rs_data),
                .i_ex_rs_data      (i_ex_rs_data),
                .i_ex_rt_data      (i_ex_rt_data),
                .upd               (upd_if.resolver),
                .rdr               (rdr_if.resolver),
                .o_flush_id        (o_flush_id),
                .o_flush_ex        (o_flush_ex)
        );

        pc_select pc_select_inst (
                .clk               (clk),
                .reset_n           (reset_n),
                .i_predicted_pc    (o_predicted_pc), // next fetch unless redirected
                .rdr               (rdr_if.selector),
                .o_pc              (o_pc),
                .o_num_branch      (o_num_branch),
                .o_num_branch_miss (o_num_branch_miss)
        );

endmodule

//--- tb/tb_next_pc_unit.sv
`timescale 1ns/1ps

module tb_next_pc_unit;
        import bpred_pkg::*;

        localparam int    NUM_ROWS     = 11;
        localparam int    NUM_CYCLES   = 100;
        localparam int    RESET_CYCLES = 4;
        localparam word_t NOP_INSTR    = 16'h4000; // opcode 4 is never a branch

        typedef enum logic [1:0] {KIND_NOP, KIND_BRANCH, KIND_JUMP} kind_e;

        // one program line with its expected outcome
        typedef struct packed {
                word_t pc;
                word_t instr;
                word_t rs;
                word_t rt;
                logic  taken;
                word_t target; // jump address or taken branch address
                kind_e kind;
        } row_t;

        logic  clk;
        logic  reset_n           = 1'b1;
        logic  i_id_valid        = 1'b0;
        word_t i_id_instr        = '0;
        word_t i_id_pc           = '0;
        word_t i_id_predicted_pc = '0;
        logic  i_id_tag_match    = 1'b0;
        word_t i_id_rs_data      = '0;
        word_t i_ex_rs_data      = '0;
        word_t i_ex_rt_data      = '0;
        word_t o_pc, o_predicted_pc, o_num_branch, o_num_branch_miss;
        logic  o_tag_match, o_flush_id, o_flush_ex;

        row_t       prog [NUM_ROWS];
        row_t       id_row;
        row_t       ex_row = '0;  // branch slot contents
        btb_entry_t m_btb [16];
        bht_ctr_t   m_ctr [16];
        word_t      m_pc = '0, m_pred = '0, m_nb = '0, m_nm = '0;
        logic       s_valid = 1'b0;
        word_t      s_pred  = '0;
        logic       f_valid = 1'b0, f_hit = 1'b0, last_flush = 1'b0;
        word_t      f_pc = '0, f_pred = '0;  // if/id latch
        integer     seed;
        int         errors = 0;

        next_pc_unit next_pc_unit_inst (.*);

        initial begin
                clk = 1'b0;
                forever begin
                        #5 clk = ~clk;
                end
        end

        initial begin
                #((RESET_CYCLES + NUM_CYCLES + 20) * 10);
                $display("timeout: the cycle loop did not finish in time");
                $display("Checks failed");
                $finish;
        end

        function automatic word_t draw_operand();
                int v;
                v = $random(seed);
                return v[15:0];
        endfunction

        // addresses outside the table read as a plain instruction
        function automatic row_t fetch_row(word_t pc);
                row_t r;
                r = '{pc, NOP_INSTR, 16'h0000, 16'h0000, 1'b0, 16'h0000, KIND_NOP};
                for (int i = 0; i < NUM_ROWS; i++) begin
                        if (prog[i].pc == pc) r = prog[i];
                end
                return r;
        endfunction

        task automatic report_mismatch(input string name, word_t got, word_t exp);
                $display("FAILED %s: got %h, expected %h", name, got, exp);
                errors++;
        endtask

        task automatic check_registered();
                if (o_pc !== m_pc) report_mismatch("o_pc", o_pc, m_pc);
                if (o_num_branch !== m_nb) report_mismatch("o_num_branch", o_num_branch, m_nb);
                if (o_num_branch_miss !== m_nm) begin
                        report_mismatch("o_num_branch_miss", o_num_branch_miss, m_nm);
                end
        endtask

        initial begin
                word_t a, b, c, pos, neg;
                seed = 32'h5581_93d5;
                a    = draw_operand();
                b    = draw_operand();
                c    = draw_operand();
                pos  = (draw_operand() & 16'h7fff) | 16'h0001;
                neg  = draw_operand() | 16'h8000;

                // ------------------------------------------------------------
                // program rows of pc, instr, rs, rt, taken, target and kind
                // ------------------------------------------------------------
                prog[0]  = '{16'h0003, 16'h9005, 16'h0000, 16'h0000, 1'b1, 16'h0005, KIND_JUMP};
                prog[1]  = '{16'h0005, 16'h1001, a, a, 1'b1, 16'h0007, KIND_BRANCH};  // beq
                prog[2]  = '{16'h0007, 16'h0010, b, b, 1'b0, 16'h0018, KIND_BRANCH};  // bne
                prog[3]  = '{16'h0008, 16'h2001, pos, b, 1'b1, 16'h000A, KIND_BRANCH};
                prog[4]  = '{16'h000A, 16'h3011, neg, a, 1'b1, 16'h001C, KIND_BRANCH};
                prog[5]  = '{16'h001C, 16'h1005, a, ~a, 1'b0, 16'h0022, KIND_BRANCH};
                prog[6]  = '{16'h001D, 16'h2005, 16'h0000, a, 1'b0, 16'h0023, KIND_BRANCH};
                prog[7]  = '{16'h001E, 16'h3005, pos, a, 1'b0, 16'h0024, KIND_BRANCH};
                prog[8]  = '{16'h001F, 16'h0009, b, b ^ 16'h0100, 1'b1, 16'h0029, KIND_BRANCH};
                prog[9]  = '{16'h0029, 16'hF019, 16'h0034, 16'h0000, 1'b1, 16'h0034, KIND_JUMP};
                prog[10] = '{16'h0036, 16'h10C9, c, c, 1'b1, 16'h0000, KIND_BRANCH}; // back to 0

                for (int i = 0; i < 16; i++) begin
                        m_btb[i] = '0;
                        m_ctr[i] = 2'd1; // weakly not taken
                end

                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                reset_n = 1'b0;

                for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
                        logic [3:0] idx;
                        logic       hit;
                        logic       live;
                        logic       jmiss;
                        logic       bmiss;
                        logic       exp_flush;
                        word_t      actual;

                        check_registered(); // first pass is the cycle out of reset

                        idx    = m_pc[3:0];
                        hit    = m_btb[idx].valid && (m_btb[idx].tag == m_pc[15:4]);
                        m_pred = (hit && (m_btb[idx].is_jump || m_ctr[idx] >= 2'd2)) ?
                                 m_btb[idx].target : m_pc + 16'd1;
                        if (o_tag_match !== hit) begin
                                report_mismatch("o_tag_match", word_t'(o_tag_match), word_t'(hit));
                        end
                        if (o_predicted_pc !== m_pred) begin
                                report_mismatch("o_predicted_pc", o_predicted_pc, m_pred);
                        end

                        // if/id register with a bubble after a flush
                        id_row            = fetch_row(f_pc);
                        i_id_valid        = f_valid && !last_flush;
                        i_id_pc           = f_pc;
                        i_id_instr        = id_row.instr;
                        i_id_predicted_pc = f_pred;
                        i_id_tag_match    = f_hit;
                        i_id_rs_data      = id_row.rs;
                        i_ex_rs_data      = ex_row.rs;
                        i_ex_rt_data      = ex_row.rt;
                        f_valid           = 1'b1;
                        f_pc              = o_pc;
                        f_pred            = o_predicted_pc;
                        f_hit             = o_tag_match;
                        #1;

                        actual    = ex_row.taken ? ex_row.target : ex_row.pc + 16'd1;
                        bmiss     = s_valid && (actual != s_pred);
                        live      = i_id_valid && !bmiss; // ex miss kills the id slot
                        jmiss     = live && id_row.kind == KIND_JUMP &&
                                    id_row.target != i_id_predicted_pc;
                        exp_flush = jmiss || bmiss;
                        if (o_flush_id !== exp_flush) begin
                                report_mismatch("o_flush_id", word_t'(o_flush_id),
                                                word_t'(exp_flush));
                        end
                        if (o_flush_ex !== bmiss) begin
                                report_mismatch("o_flush_ex", word_t'(o_flush_ex), word_t'(bmiss));
                        end
                        last_flush = o_flush_id;

                        // ------------------------------------------------------------
                        // model state at the next edge
                        // ------------------------------------------------------------
                        m_nb = m_nb + word_t'(live && id_row.kind == KIND_JUMP) +
                               word_t'(s_valid);
                        if (exp_flush) m_nm = m_nm + 16'd1;
                        m_pc = bmiss ? actual : (jmiss ? id_row.target : m_pred);
                        if (s_valid) begin // steps the counter held before this edge
                                idx = ex_row.pc[3:0];
                                if (ex_row.taken && m_ctr[idx] != 2'd3) begin
                                        m_ctr[idx] = m_ctr[idx] + 2'd1;
                                end
                                if (!ex_row.taken && m_ctr[idx] != 2'd0) begin
                                        m_ctr[idx] = m_ctr[idx] - 2'd1;
                                end
                        end
                        if (live && id_row.kind != KIND_NOP && !i_id_tag_match) begin
                                idx        = i_id_pc[3:0];
                                m_btb[idx] = '{1'b1, i_id_pc[15:4], id_row.target,
                                               id_row.kind == KIND_JUMP};
                                if (!(s_valid && ex_row.pc[3:0] == idx)) begin
                                        m_ctr[idx] = 2'd1; // same-index update wins
                                end
                        end
                        s_valid = live && id_row.kind == KIND_BRANCH;
                        s_pred  = i_id_predicted_pc;
                        ex_row  = id_row;
                        @(negedge clk);
                end

                check_registered();
                $display("errors %0d after %0d cycles, branches %0d, misses %0d",
                         errors, NUM_CYCLES, m_nb, m_nm);
                if (errors == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

endmodule

//--- compile.f
+incdir+source
source/bpred_pkg.sv
source/bpred_ifc.sv
source/branch_predictor.sv
source/branch_resolver.sv
source/pc_select.sv
source/next_pc_unit.sv
tb/tb_next_pc_unit.sv

//--- run.sh
#!/bin/sh
# build the next-pc testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_next_pc_unit -f compile.f -o sim_next_pc &&
./obj_dir/sim_next_pc | tee /dev/stderr | grep "All checks passed" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
